/* fetchPkg.sv */
// Fetch package
// Widths, control-type encoding and the per-slot prediction and training
// records shared by the first fetch stage and its lookup tables
`default_nettype none

package fetchPkg;

	localparam int FETCH_WIDTH  = 4;	// Slots per bundle
	localparam int INST_BYTES   = 8;	// Bytes per instruction
	localparam int BUNDLE_BYTES = 32;	// Bytes per fetch bundle

	typedef logic [31:0] pcT;	// Byte address
	typedef logic [63:0] instT;	// One instruction
	typedef instT [FETCH_WIDTH-1:0] bundleT;	// Slot 0 in the low bits

	// Control instruction type, same code on lookup and update
	typedef logic [1:0] ctrlTypeT;
	localparam ctrlTypeT CT_RETURN = 2'b00;
	localparam ctrlTypeT CT_CALL   = 2'b01;
	localparam ctrlTypeT CT_JUMP   = 2'b10;
	localparam ctrlTypeT CT_COND   = 2'b11;

	// Prediction for one slot of the bundle
	typedef struct packed {
		logic     btbHit;	// BTB entry matched
		ctrlTypeT ctrlType;	// Type stored in the entry
		pcT       target;	// Predicted target
		logic     taken;	// Slot redirects fetch
	} slotPredT;

	// Resolved branch, in program order from retire
	typedef struct packed {
		logic     en;	// One-cycle strobe
		pcT       pc;	// Branch address
		pcT       target;	// Resolved target
		ctrlTypeT brType;	// Control type
		logic     dir;	// Resolved direction, 1 is taken
	} brUpdateT;

endpackage

`default_nettype wire

/* icachePkg.sv */
// Instruction cache package
// Block offset and the refill record from the next memory level
`default_nettype none

package icachePkg;

	// 32-byte block, one full bundle per line
	localparam int OFFSET_BITS = 5;

	// Refill write from the next level
	typedef struct packed {
		logic             wrEn;	// One-cycle write strobe
		fetchPkg::pcT     wrAddr;	// Any address inside the block
		fetchPkg::bundleT block;	// Full line of data
	} refillT;

endpackage

`default_nettype wire

/* btb.sv */
// Branch target buffer
// Direct-mapped on the instruction address, four combinational read ports
// for the bundle slots and one write port for in-order training
`timescale 1ns/1ps
`default_nettype none

module btb #(
	parameter int BTB_ENTRIES = 16
) (
	input  logic                                       clk,
	input  logic                                       reset,
	input  fetchPkg::pcT                               fetchPc_i,	// Bundle PC
	input  fetchPkg::brUpdateT                         update_i,	// Already gated by type
	output logic [fetchPkg::FETCH_WIDTH-1:0]           hit_o,
	output fetchPkg::ctrlTypeT [fetchPkg::FETCH_WIDTH-1:0] ctrlType_o,
	output fetchPkg::pcT [fetchPkg::FETCH_WIDTH-1:0]   target_o
);

	import fetchPkg::*;

	localparam int INST_SHIFT = $clog2(INST_BYTES);	// Index starts above the byte offset
	localparam int IDX_BITS   = $clog2(BTB_ENTRIES);
	localparam int TAG_LSB    = INST_SHIFT + IDX_BITS;
	localparam int TAG_BITS   = $bits(pcT) - TAG_LSB;

	typedef logic [IDX_BITS-1:0] btbIdxT;
	typedef logic [TAG_BITS-1:0] btbTagT;

	typedef struct packed {
		btbTagT   tag;
		ctrlTypeT ctrlType;
		pcT       target;
	} btbEntryT;

	logic [BTB_ENTRIES-1:0] valid;	// Cleared on reset
	btbEntryT               entries [BTB_ENTRIES];	// Payload, no reset
	btbIdxT                 wrIdx;

	assign wrIdx = update_i.pc[INST_SHIFT +: IDX_BITS];

	// One read port per slot, slot k looks at PC plus 8k
	always_comb
	begin
		pcT     slotPc;
		btbIdxT rdIdx;
		for (int k = 0; k < FETCH_WIDTH; k++)
		begin
			slotPc        = fetchPc_i + pcT'(k * INST_BYTES);
			rdIdx         = slotPc[INST_SHIFT +: IDX_BITS];
			hit_o[k]      = valid[rdIdx] && (entries[rdIdx].tag == slotPc[TAG_LSB +: TAG_BITS]);
			ctrlType_o[k] = entries[rdIdx].ctrlType;	// Meaningless on a miss
			target_o[k]   = entries[rdIdx].target;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			valid <= '0;
		else if (update_i.en)
			valid[wrIdx] <= 1'b1;	// Replaces whatever was there
	end

	always_ff @(posedge clk)
	begin
		if (update_i.en)
		begin
			entries[wrIdx].tag      <= update_i.pc[TAG_LSB +: TAG_BITS];
			entries[wrIdx].ctrlType <= update_i.brType;
			entries[wrIdx].target   <= update_i.target;
		end
	end

endmodule

`default_nettype wire

/* branchPredictor.sv */
// Bimodal direction predictor
// Table of two-bit saturating counters, four-slot lookup and in-order training
`timescale 1ns/1ps
`default_nettype none

module branchPredictor #(
	parameter int BP_ENTRIES = 64
) (
	input  logic                             clk,
	input  logic                             reset,
	input  fetchPkg::pcT                     fetchPc_i,	// Bundle PC
	input  fetchPkg::brUpdateT               update_i,	// Conditional branches only
	output logic [fetchPkg::FETCH_WIDTH-1:0] taken_o
);

	import fetchPkg::*;

	localparam int INST_SHIFT = $clog2(INST_BYTES);
	localparam int IDX_BITS   = $clog2(BP_ENTRIES);

	typedef logic [1:0]          bpCtrT;	// 0,1 not taken, 2,3 taken
	typedef logic [IDX_BITS-1:0] bpIdxT;

	bpCtrT counters [BP_ENTRIES];
	bpIdxT wrIdx;

	assign wrIdx = update_i.pc[INST_SHIFT +: IDX_BITS];

	// Upper counter bit is the prediction
	always_comb
	begin
		pcT slotPc;
		for (int k = 0; k < FETCH_WIDTH; k++)
		begin
			slotPc     = fetchPc_i + pcT'(k * INST_BYTES);
			taken_o[k] = counters[slotPc[INST_SHIFT +: IDX_BITS]][1];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < BP_ENTRIES; i++)
				counters[i] <= 2'b01;	// Weakly not taken
		end
		else if (update_i.en)
		begin
			if (update_i.dir && counters[wrIdx] != 2'b11)
				counters[wrIdx] <= counters[wrIdx] + 2'b01;	// Toward taken
			else if (!update_i.dir && counters[wrIdx] != 2'b00)
				counters[wrIdx] <= counters[wrIdx] - 2'b01;	// Toward not taken
		end
	end

endmodule

`default_nettype wire

/* returnAddrStack.sv */
// Return address stack
// Circular stack, pushed on predicted calls and popped on predicted returns;
// a decode redirect overrides the predicted action in the same cycle
`timescale 1ns/1ps
`default_nettype none

module returnAddrStack #(
	parameter int RAS_DEPTH = 8
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         push_i,	// Predicted call
	input  fetchPkg::pcT pushAddr_i,	// Return address of that call
	input  logic         pop_i,	// Predicted return
	input  logic         recoverId_i,	// Decode redirect
	input  logic         callId_i,	// Redirect is a call missed by the BTB
	input  fetchPkg::pcT callPcId_i,
	input  logic         rtrId_i,	// Redirect is a return missed by the BTB
	output fetchPkg::pcT top_o
);

	import fetchPkg::*;

	localparam int PTR_BITS = $clog2(RAS_DEPTH);

	typedef logic [PTR_BITS-1:0] rasPtrT;

	pcT     stack [RAS_DEPTH];
	rasPtrT tos;	// Points at the current top
	rasPtrT tosUp;
	logic   doPush;
	logic   doPop;
	pcT     wrAddr;

	assign tosUp = tos + 1'b1;	// Wraps, oldest entry is overwritten
	assign top_o = stack[tos];

	// Decode redirect has precedence over prediction
	always_comb
	begin
		if (recoverId_i)
		begin
			doPush = callId_i;
			doPop  = rtrId_i;
			wrAddr = callPcId_i + pcT'(INST_BYTES);	// Return lands after the call
		end
		else
		begin
			doPush = push_i;
			doPop  = pop_i;
			wrAddr = pushAddr_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tos <= '0;
			for (int i = 0; i < RAS_DEPTH; i++)
				stack[i] <= '0;	// Empty stack reads as address zero
		end
		else if (doPush)
		begin
			tos          <= tosUp;
			stack[tosUp] <= wrAddr;
		end
		else if (doPop)
			tos <= tos - 1'b1;	// Underflow wraps as well
	end

endmodule

`default_nettype wire

/* l1ICache.sv */
// L1 instruction cache
// Direct-mapped, one bundle per line; combinational tag compare on the fetch PC,
// miss address to the next level and a full-line refill port
`timescale 1ns/1ps
`default_nettype none

module l1ICache #(
	parameter int ICACHE_SETS = 16
) (
	input  logic              clk,
	input  logic              reset,
	input  fetchPkg::pcT      fetchPc_i,
	input  icachePkg::refillT refill_i,
	output fetchPkg::bundleT  bundle_o,
	output logic              miss_o,
	output fetchPkg::pcT      missAddr_o
);

	import fetchPkg::*;
	import icachePkg::*;

	localparam int INDEX_BITS = $clog2(ICACHE_SETS);
	localparam int TAG_LSB    = OFFSET_BITS + INDEX_BITS;
	localparam int TAG_BITS   = $bits(pcT) - TAG_LSB;

	typedef logic [INDEX_BITS-1:0] cacheIndexT;
	typedef logic [TAG_BITS-1:0]   cacheTagT;

	bundleT           dataArr [ICACHE_SETS];	// Line data
	cacheTagT         tagArr  [ICACHE_SETS];
	logic [ICACHE_SETS-1:0] valid;

	cacheIndexT rdIdx;
	cacheTagT   rdTag;
	cacheIndexT wrIdx;
	cacheTagT   wrTag;

	assign rdIdx = fetchPc_i[OFFSET_BITS +: INDEX_BITS];
	assign rdTag = fetchPc_i[TAG_LSB +: TAG_BITS];
	assign wrIdx = refill_i.wrAddr[OFFSET_BITS +: INDEX_BITS];
	assign wrTag = refill_i.wrAddr[TAG_LSB +: TAG_BITS];

	// Read path, same cycle as the PC
	assign bundle_o   = dataArr[rdIdx];
	assign miss_o     = !(valid[rdIdx] && tagArr[rdIdx] == rdTag);
	assign missAddr_o = {fetchPc_i[$bits(pcT)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};	// Block aligned

	always_ff @(posedge clk)
	begin
		if (reset)
			valid <= '0;	// Every line misses after reset
		else if (refill_i.wrEn)
			valid[wrIdx] <= 1'b1;
	end

	// Refilled line hits from the next cycle
	always_ff @(posedge clk)
	begin
		if (refill_i.wrEn)
		begin
			dataArr[wrIdx] <= refill_i.block;
			tagArr[wrIdx]  <= wrTag;
		end
	end

endmodule

`default_nettype wire

/* fetchStage1.sv */
// First fetch stage of the four-wide core
// PC register, bundle fetch from the L1 instruction cache, four-slot branch
// prediction and the next-PC priority encoder with return stack control
`timescale 1ns/1ps
`default_nettype none

module fetchStage1 #(
	parameter int           BTB_ENTRIES = 16,
	parameter int           BP_ENTRIES  = 64,
	parameter int           RAS_DEPTH   = 8,
	parameter int           ICACHE_SETS = 16,
	parameter fetchPkg::pcT RESET_PC    = '0
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    stall_i,	// Level, holds the PC
	input  logic                    recoverFlag_i,	// Core recovery
	input  fetchPkg::pcT            recoverPc_i,
	input  logic                    exceptionFlag_i,
	input  fetchPkg::pcT            exceptionPc_i,
	input  logic                    recoverEx_i,	// Execute redirect
	input  fetchPkg::pcT            targetEx_i,
	input  logic                    recoverId_i,	// Decode redirect
	input  logic                    callId_i,
	input  logic                    rtrId_i,
	input  fetchPkg::pcT            callPcId_i,
	input  fetchPkg::pcT            targetId_i,
	input  fetchPkg::brUpdateT      update_i,	// Retire-side training
	input  icachePkg::refillT       refill_i,	// Line refill
	output logic                    ready_o,
	output fetchPkg::bundleT        bundle_o,
	output fetchPkg::pcT            pc_o,	// Next PC
	output fetchPkg::slotPredT [fetchPkg::FETCH_WIDTH-1:0] pred_o,
	output logic                    miss_o,
	output fetchPkg::pcT            missAddr_o
);

	import fetchPkg::*;

	pcT       pcReg;	// Only steering state
	pcT       nextPc;
	brUpdateT btbUpd;
	brUpdateT bpUpd;
	logic     miss;
	logic     advance;	// PC loads nextPc this edge

	logic [FETCH_WIDTH-1:0]     btbHit;
	ctrlTypeT [FETCH_WIDTH-1:0] btbType;
	pcT [FETCH_WIDTH-1:0]       btbTarget;
	logic [FETCH_WIDTH-1:0]     bpTaken;
	slotPredT [FETCH_WIDTH-1:0] slotPred;

	logic pushReq;
	logic popReq;
	pcT   pushAddr;
	pcT   rasTop;

	// Conditional branches enter the BTB only when taken
	always_comb
	begin
		btbUpd    = update_i;
		bpUpd     = update_i;
		btbUpd.en = update_i.en && (update_i.brType != CT_COND || update_i.dir);
		bpUpd.en  = update_i.en && update_i.brType == CT_COND;	// Counters see only conditionals
	end

	btb #(.BTB_ENTRIES(BTB_ENTRIES)) btb0 (
		.clk        (clk),
		.reset      (reset),
		.fetchPc_i  (pcReg),
		.update_i   (btbUpd),
		.hit_o      (btbHit),
		.ctrlType_o (btbType),
		.target_o   (btbTarget)
	);

	branchPredictor #(.BP_ENTRIES(BP_ENTRIES)) bp0 (
		.clk       (clk),
		.reset     (reset),
		.fetchPc_i (pcReg),
		.update_i  (bpUpd),
		.taken_o   (bpTaken)
	);

	// Stack moves only when the PC moves, and decode acts only when it is the chosen source
	returnAddrStack #(.RAS_DEPTH(RAS_DEPTH)) ras0 (
		.clk         (clk),
		.reset       (reset),
		.push_i      (pushReq && advance && !recoverEx_i && !recoverId_i),
		.pushAddr_i  (pushAddr),
		.pop_i       (popReq && advance && !recoverEx_i && !recoverId_i),
		.recoverId_i (recoverId_i && advance && !recoverEx_i),
		.callId_i    (callId_i),
		.callPcId_i  (callPcId_i),
		.rtrId_i     (rtrId_i),
		.top_o       (rasTop)
	);

	l1ICache #(.ICACHE_SETS(ICACHE_SETS)) icache0 (
		.clk        (clk),
		.reset      (reset),
		.fetchPc_i  (pcReg),
		.refill_i   (refill_i),
		.bundle_o   (bundle_o),
		.miss_o     (miss),
		.missAddr_o (missAddr_o)
	);

	// Merge per-slot results, a non-conditional hit is always taken
	always_comb
	begin
		for (int k = 0; k < FETCH_WIDTH; k++)
		begin
			slotPred[k].btbHit   = btbHit[k];
			slotPred[k].ctrlType = btbType[k];
			slotPred[k].target   = btbTarget[k];
			slotPred[k].taken    = btbHit[k] && (bpTaken[k] || btbType[k] != CT_COND);
			pred_o[k]            = slotPred[k];
			if (btbType[k] == CT_RETURN)
				pred_o[k].target = rasTop;	// Returns go where the stack says
		end
	end

	// Next-PC priority encoder, lowest priority assigned first
	always_comb
	begin
		logic found;
		found    = 1'b0;
		pushReq  = 1'b0;
		popReq   = 1'b0;
		pushAddr = pcReg + pcT'(INST_BYTES);
		nextPc   = pcReg + pcT'(BUNDLE_BYTES);	// Sequential bundle
		for (int k = 0; k < FETCH_WIDTH; k++)
		begin
			if (!found && slotPred[k].taken)	// First taken slot only
			begin
				found = 1'b1;
				if (slotPred[k].ctrlType == CT_RETURN)
				begin
					nextPc = rasTop;
					popReq = 1'b1;
				end
				else if (slotPred[k].ctrlType == CT_CALL)
				begin
					nextPc   = slotPred[k].target;
					pushReq  = 1'b1;
					pushAddr = pcReg + pcT'(INST_BYTES * (k + 1));	// Slot after the call
				end
				else
					nextPc = slotPred[k].target;
			end
		end
		if (recoverId_i)
			nextPc = rtrId_i ? rasTop : targetId_i;	// Missed return uses current top
		if (recoverEx_i)
			nextPc = targetEx_i;
	end

	// Execute redirect moves the PC even under stall or miss
	assign advance = !recoverFlag_i && !exceptionFlag_i && (recoverEx_i || (!stall_i && !miss));

	always_ff @(posedge clk)
	begin
		if (reset)
			pcReg <= RESET_PC;
		else if (recoverFlag_i)
			pcReg <= recoverPc_i;
		else if (exceptionFlag_i)
			pcReg <= exceptionPc_i;
		else if (advance)
			pcReg <= nextPc;
	end

	assign pc_o    = nextPc;
	assign miss_o  = miss;
	assign ready_o = !miss;	// Decode waits on a miss

endmodule

`default_nettype wire

/* fetchStage1_props.sv */
// Fetch stage properties
// Concurrent checks bound to the first fetch stage: ready against miss,
// PC hold under stall and recovery priority over exception
`timescale 1ns/1ps
`default_nettype none

module fetchStage1_props (
	input logic         clk,
	input logic         reset,
	input logic         stall_i,
	input logic         recoverFlag_i,
	input fetchPkg::pcT recoverPc_i,
	input logic         exceptionFlag_i,
	input logic         recoverEx_i,
	input logic         miss_i,	// DUT miss_o
	input logic         ready_i,	// DUT ready_o
	input fetchPkg::pcT pcReg_i	// Internal PC register
);

	// Ready is always the inverse of miss
	readyNotMiss: assert property (@(posedge clk) disable iff (reset) miss_i != ready_i)
		else $error("miss_o and ready_o carry the same value");

	// Stall with no redirect keeps the PC
	stallHolds: assert property (@(posedge clk) disable iff (reset)
		(stall_i && !recoverFlag_i && !exceptionFlag_i && !recoverEx_i) |=> $stable(pcReg_i))
		else $error("PC moved during a stall with no redirect");

	// Core recovery beats an exception in the same cycle
	recoverFirst: assert property (@(posedge clk) disable iff (reset)
		(recoverFlag_i && exceptionFlag_i) |=> (pcReg_i == $past(recoverPc_i)))
		else $error("PC did not load the recovery address over the exception address");

endmodule

`default_nettype wire

/* tb_fetchStage1.sv */
// Testbench for the first fetch stage
// Directed tests with own models of the cache lines, BTB, counters and
// return stack; expected next PC comes from those models
`timescale 1ns/1ps
`default_nettype none

module tb_fetchStage1;

	import fetchPkg::*;
	import icachePkg::*;

	localparam int          CLK_PERIOD     = 20;
	localparam int          RESET_CYCLES   = 16;
	localparam int          TIMEOUT_CYCLES = 2000;	// Directed run needs about 120 cycles
	localparam int unsigned RAND_SEED      = 32'h8e14;
	localparam pcT          RESET_PC       = '0;
	localparam int          CACHE_BYTES    = 512;	// 16 sets of one bundle

	logic     clk;
	logic     reset;
	logic     stall;
	logic     recoverFlag;
	pcT       recoverPc;
	logic     exceptionFlag;
	pcT       exceptionPc;
	logic     recoverEx;
	pcT       targetEx;
	logic     recoverId;
	logic     callId;
	logic     rtrId;
	pcT       callPcId;
	pcT       targetId;
	brUpdateT update;
	refillT   refill;
	logic     ready;
	bundleT   bundle;
	pcT       pcNext;	// DUT pc_o
	slotPredT [FETCH_WIDTH-1:0] pred;
	logic     miss;
	pcT       missAddr;

	bundleT   memModel [pcT];	// Lines written so far
	ctrlTypeT btbTypeModel [pcT];
	pcT       btbTargetModel [pcT];
	int       ctrModel [pcT];	// Missing key reads as 1
	pcT       rasModel [$];
	pcT       curPc;	// Expected PC register
	int       errors;
	int       checks;

	fetchStage1 dut0 (
		.clk             (clk),
		.reset           (reset),
		.stall_i         (stall),
		.recoverFlag_i   (recoverFlag),
		.recoverPc_i     (recoverPc),
		.exceptionFlag_i (exceptionFlag),
		.exceptionPc_i   (exceptionPc),
		.recoverEx_i     (recoverEx),
		.targetEx_i      (targetEx),
		.recoverId_i     (recoverId),
		.callId_i        (callId),
		.rtrId_i         (rtrId),
		.callPcId_i      (callPcId),
		.targetId_i      (targetId),
		.update_i        (update),
		.refill_i        (refill),
		.ready_o         (ready),
		.bundle_o        (bundle),
		.pc_o            (pcNext),
		.pred_o          (pred),
		.miss_o          (miss),
		.missAddr_o      (missAddr)
	);

	bind fetchStage1 fetchStage1_props props0 (
		.clk             (clk),
		.reset           (reset),
		.stall_i         (stall_i),
		.recoverFlag_i   (recoverFlag_i),
		.recoverPc_i     (recoverPc_i),
		.exceptionFlag_i (exceptionFlag_i),
		.recoverEx_i     (recoverEx_i),
		.miss_i          (miss_o),
		.ready_i         (ready_o),
		.pcReg_i         (pcReg)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run stopped making progress", TIMEOUT_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	function automatic pcT blockOf(input pcT pc);
		return pc & ~pcT'(BUNDLE_BYTES - 1);	// Cache returns the aligned line
	endfunction

	function automatic pcT stackTop();
		if (rasModel.size() == 0)
			return RESET_PC;	// Empty stack
		return rasModel[$];
	endfunction

	function automatic logic ctrTaken(input pcT pc);
		if (!ctrModel.exists(pc))
			return 1'b0;	// Weakly not taken
		return ctrModel[pc] >= 2;
	endfunction

	// First taken slot decides, else the next bundle
	function automatic void predict(input pcT pc, output pcT nextPc, output int slot,
		output ctrlTypeT ty);
		pcT slotPc;
		nextPc = pc + pcT'(BUNDLE_BYTES);
		slot   = -1;
		ty     = CT_JUMP;
		for (int k = 0; k < FETCH_WIDTH; k++)
		begin
			slotPc = pc + pcT'(k * INST_BYTES);
			if (slot < 0 && btbTypeModel.exists(slotPc)
				&& (btbTypeModel[slotPc] != CT_COND || ctrTaken(slotPc)))
			begin
				slot   = k;
				ty     = btbTypeModel[slotPc];
				nextPc = (ty == CT_RETURN) ? stackTop() : btbTargetModel[slotPc];
			end
		end
	endfunction

	function automatic bundleT randBundle();
		bundleT b;
		for (int k = 0; k < FETCH_WIDTH; k++)
			b[k] = {$urandom(), $urandom()};
		return b;
	endfunction

	task automatic tick();
		@(posedge clk);
		#2;	// Drive point
	endtask

	task automatic settle();
		#5;	// Combinational outputs stable
	endtask

	task automatic checkVal(input string test, input string what, input pcT exp, input pcT act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERR %s: %s expected %h actual %h", test, what, exp, act);
		end
	endtask

	task automatic checkFetch(input string test);
		pcT       expNext;
		int       slot;
		ctrlTypeT ty;
		predict(curPc, expNext, slot, ty);
		checkVal(test, "missAddr_o", blockOf(curPc), missAddr);
		checkVal(test, "pc_o", expNext, pcNext);
		checks++;
		if (memModel.exists(blockOf(curPc)) && bundle !== memModel[blockOf(curPc)])
		begin
			errors++;
			$display("ERR %s: bundle_o expected %h actual %h", test,
				memModel[blockOf(curPc)], bundle);
		end
	endtask

	// Let the PC advance n times, stack follows the predicted call or return
	task automatic runCycles(input string test, input int n);
		pcT       expNext;
		int       slot;
		ctrlTypeT ty;
		stall = 1'b0;
		repeat (n)
		begin
			settle();
			checkFetch(test);
			if (miss)
			begin
				errors++;
				$display("Fetch at %h missed in the cache during %s", curPc, test);
			end
			predict(curPc, expNext, slot, ty);
			tick();
			if (slot >= 0 && ty == CT_CALL)
				rasModel.push_back(curPc + pcT'(INST_BYTES * (slot + 1)));
			else if (slot >= 0 && ty == CT_RETURN)
				void'(rasModel.pop_back());
			curPc = expNext;
		end
		stall = 1'b1;
	endtask

	task automatic holdCycles(input string test, input int n);
		pcT       held;
		int       slot;
		ctrlTypeT ty;
		stall = 1'b1;
		predict(curPc, held, slot, ty);	// Next PC of the held bundle
		settle();
		repeat (n)
		begin
			checkFetch(test);
			checkVal(test, "held pc_o", held, pcNext);
			tick();
			settle();
		end
		tick();
	endtask

	task automatic jumpTo(input pcT pc);
		recoverFlag = 1'b1;	// Core recovery places the PC
		recoverPc   = pc;
		tick();
		recoverFlag = 1'b0;
		curPc       = pc;
	endtask

	task automatic sendUpdate(input pcT pc, input pcT target, input ctrlTypeT ty, input logic dir);
		update.en     = 1'b1;
		update.pc     = pc;
		update.target = target;
		update.brType = ty;
		update.dir    = dir;
		if (ty == CT_COND)
		begin
			if (!ctrModel.exists(pc))
				ctrModel[pc] = 1;
			if (dir && ctrModel[pc] < 3)
				ctrModel[pc]++;
			else if (!dir && ctrModel[pc] > 0)
				ctrModel[pc]--;
		end
		if (ty != CT_COND || dir)
		begin
			btbTypeModel[pc]   = ty;	// Not-taken conditionals stay out of the BTB
			btbTargetModel[pc] = target;
		end
		tick();
		update.en = 1'b0;
	endtask

	task automatic fillLine(input pcT addr);
		refill.wrEn   = 1'b1;
		refill.wrAddr = addr;
		refill.block  = randBundle();
		memModel[blockOf(addr)] = refill.block;
		tick();
		refill.wrEn = 1'b0;
	endtask

	task automatic decodeRedirect(input string test, input logic isCall, input logic isRtr,
		input pcT callPc, input pcT target);
		pcT expNext;
		expNext   = isRtr ? stackTop() : target;	// Missed return uses the current top
		recoverId = 1'b1;
		callId    = isCall;
		rtrId     = isRtr;
		callPcId  = callPc;
		targetId  = target;
		stall     = 1'b0;
		settle();
		checkVal(test, "pc_o", expNext, pcNext);
		tick();
		if (isCall)
			rasModel.push_back(callPc + pcT'(INST_BYTES));
		else if (isRtr)
			void'(rasModel.pop_back());
		curPc     = expNext;
		recoverId = 1'b0;
		callId    = 1'b0;
		rtrId     = 1'b0;
		holdCycles(test, 1);
	endtask

	task automatic testMissRefill();
		int waitCount;
		settle();
		checkVal("missRefill", "miss_o", pcT'(1), pcT'(miss));	// All lines invalid
		checkVal("missRefill", "ready_o", pcT'(0), pcT'(ready));
		checkVal("missRefill", "missAddr_o", RESET_PC, missAddr);
		tick();
		fillLine(blockOf(RESET_PC));
		settle();
		waitCount = 0;
		while (!ready && waitCount < 4)
		begin
			tick();
			settle();
			waitCount++;
		end
		if (!ready)
		begin
			errors++;
			$display("ready_o did not rise within 4 cycles of the refill");
		end
		checkFetch("missRefill");
		checkVal("missRefill", "pc_o", RESET_PC + pcT'(BUNDLE_BYTES), pcNext);
		tick();
		for (int a = BUNDLE_BYTES; a < CACHE_BYTES; a += BUNDLE_BYTES)
			fillLine(pcT'(a));
	endtask

	task automatic testSequential();
		jumpTo(32'h0000_0020);
		runCycles("sequential", 6);	// Empty BTB, plus 32 per cycle
		holdCycles("stall", 3);
	endtask

	task automatic testBranches();
		sendUpdate(32'h0000_0050, 32'h0000_0100, CT_JUMP, 1'b1);	// Slot 2 of bundle 0x40
		jumpTo(32'h0000_0040);
		settle();
		checkVal("jump", "pred_o[2].btbHit", pcT'(1), pcT'(pred[2].btbHit));
		checkVal("jump", "pred_o[1].btbHit", pcT'(0), pcT'(pred[1].btbHit));
		checkVal("jump", "pred_o[2].target", 32'h0000_0100, pred[2].target);
		checkVal("jump", "pc_o", 32'h0000_0100, pcNext);
		tick();
		runCycles("jump", 1);
		holdCycles("jump", 1);
		sendUpdate(32'h0000_0088, 32'h0000_0180, CT_COND, 1'b0);	// Counter down to 0
		sendUpdate(32'h0000_0088, 32'h0000_0180, CT_COND, 1'b1);	// Enters BTB, counter 1
		jumpTo(32'h0000_0080);
		settle();
		checkVal("condOnce", "pred_o[1].btbHit", pcT'(1), pcT'(pred[1].btbHit));
		checkVal("condOnce", "pred_o[1].taken", pcT'(0), pcT'(pred[1].taken));
		checkVal("condOnce", "pc_o", 32'h0000_00a0, pcNext);
		tick();
		sendUpdate(32'h0000_0088, 32'h0000_0180, CT_COND, 1'b1);
		settle();
		checkVal("condTwice", "pred_o[1].taken", pcT'(1), pcT'(pred[1].taken));
		checkVal("condTwice", "pc_o", 32'h0000_0180, pcNext);
		tick();
		runCycles("condTwice", 1);
		holdCycles("condTwice", 1);
	endtask

	task automatic testCallReturn();
		sendUpdate(32'h0000_00c8, 32'h0000_0140, CT_CALL, 1'b1);	// Slot 1 of bundle 0xC0
		sendUpdate(32'h0000_0140, 32'h0000_0000, CT_RETURN, 1'b1);	// Slot 0 of bundle 0x140
		jumpTo(32'h0000_00c0);
		settle();
		checkVal("call", "pred_o[1].taken", pcT'(1), pcT'(pred[1].taken));
		checkVal("call", "pred_o[1].ctrlType", pcT'(CT_CALL), pcT'(pred[1].ctrlType));
		checkVal("call", "pc_o", 32'h0000_0140, pcNext);
		tick();
		runCycles("call", 1);
		settle();
		checkVal("return", "pred_o[0].ctrlType", pcT'(CT_RETURN), pcT'(pred[0].ctrlType));
		checkVal("return", "pred_o[0].target", 32'h0000_00d0, pred[0].target);
		checkVal("return", "pc_o", 32'h0000_00d0, pcNext);	// Call bundle plus 16
		tick();
		runCycles("return", 1);
		holdCycles("return", 1);
		decodeRedirect("decodeCall", 1'b1, 1'b0, 32'h0000_01a0, 32'h0000_01c0);
		decodeRedirect("decodeReturn", 1'b0, 1'b1, 32'h0000_0000, 32'h0000_0000);
	endtask

	// All four redirects at once, then drop them from the top
	task automatic testPriority();
		stall         = 1'b1;
		recoverFlag   = 1'b1;
		recoverPc     = 32'h0000_0020;
		exceptionFlag = 1'b1;
		exceptionPc   = 32'h0000_0060;
		recoverEx     = 1'b1;
		targetEx      = 32'h0000_00a0;
		recoverId     = 1'b1;
		targetId      = 32'h0000_00e0;
		settle();
		checkVal("priority", "pc_o", 32'h0000_00a0, pcNext);	// Execute over decode
		tick();
		recoverFlag = 1'b0;
		settle();
		checkVal("priorityRecover", "missAddr_o", 32'h0000_0020, missAddr);
		tick();
		exceptionFlag = 1'b0;
		settle();
		checkVal("priorityException", "missAddr_o", 32'h0000_0060, missAddr);
		tick();
		recoverEx = 1'b0;
		settle();
		checkVal("priorityExecute", "missAddr_o", 32'h0000_00a0, missAddr);	// Loaded under stall
		checkVal("priorityExecute", "pc_o", 32'h0000_00e0, pcNext);
		tick();
		stall = 1'b0;
		settle();
		checkVal("priorityStall", "missAddr_o", 32'h0000_00a0, missAddr);	// Decode held by stall
		tick();
		recoverId = 1'b0;
		stall     = 1'b1;
		curPc     = 32'h0000_00e0;
		holdCycles("priorityDecode", 1);
	endtask

	initial
	begin
		void'($urandom(RAND_SEED));
		errors        = 0;
		checks        = 0;
		curPc         = RESET_PC;
		reset         = 1'b1;
		stall         = 1'b1;
		recoverFlag   = 1'b0;
		recoverPc     = '0;
		exceptionFlag = 1'b0;
		exceptionPc   = '0;
		recoverEx     = 1'b0;
		targetEx      = '0;
		recoverId     = 1'b0;
		callId        = 1'b0;
		rtrId         = 1'b0;
		callPcId      = '0;
		targetId      = '0;
		update        = '0;
		refill        = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset = 1'b0;
		testMissRefill();
		testSequential();
		testBranches();
		testCallReturn();
		testPriority();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
fetchPkg.sv
icachePkg.sv
btb.sv
branchPredictor.sv
returnAddrStack.sv
l1ICache.sv
fetchStage1.sv
fetchStage1_props.sv
tb_fetchStage1.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_fetchStage1
FILELIST  = compile.f
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run ended without a verdict"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
